// ==== Bender.yml ====
package:
  name: tap_ctrl

sources:
  - files:
      - hw/tap_pkg.sv
      - hw/tap_fsm.sv
      - hw/tap_instr_reg.sv
      - hw/tap_dr_shift_reg.sv
      - hw/tap_data_path.sv
      - hw/tap_ctrl_top.sv
  - target: simulation
    files:
      - verification/tb_tap_ctrl.sv

// ==== compile.f ====
hw/tap_pkg.sv
hw/tap_fsm.sv
hw/tap_instr_reg.sv
hw/tap_dr_shift_reg.sv
hw/tap_data_path.sv
hw/tap_ctrl_top.sv
verification/tb_tap_ctrl.sv

// ==== hw/tap_ctrl_top.sv ====
// ----------------------------------------------------------
// Top level of the JTAG TAP controller for the debug transport
// Chains the state machine, instruction register and data path
// BUILD_ID sets the value read back by the BLD_ID instruction
// ----------------------------------------------------------

`default_nettype none
`timescale 1ns/100ps

module tap_ctrl_top
    import tap_pkg::*;
#(
    parameter logic [TAP_BLD_ID_WIDTH-1:0] BUILD_ID = 32'h2021_0607
) (
    input  logic                        tapc_tck,
    input  logic                        tapc_trst_n,
    input  logic                        tms_i,
    input  logic                        tdi_i,
    output logic                        tdo_o,
    output logic                        tdo_en_o,
    input  logic [TAP_IDCODE_WIDTH-1:0] fuse_idcode_i,
    output tap_chain_req_t              chain_req_o,
    input  logic                        ch_tdo_i
);

    tap_ir_ctrl_t ir_ctrl;
    tap_dr_ctrl_t dr_ctrl;
    logic         ir_shift_q;
    // Synchronous reset from Test-Logic-Reset
    logic         tlr_rst_n;
    tap_instr_e   instr;
    logic         ir_tdo;

    // State machine and strobes
    tap_fsm u_fsm (
        .tapc_tck    (tapc_tck),
        .tapc_trst_n (tapc_trst_n),
        .tms_i       (tms_i),
        .ir_ctrl_o   (ir_ctrl),
        .dr_ctrl_o   (dr_ctrl),
        .ir_shift_q_o(ir_shift_q),
        .tlr_rst_n_o (tlr_rst_n)
    );

    tap_instr_reg u_instr_reg (
        .tapc_tck   (tapc_tck),
        .tapc_trst_n(tapc_trst_n),
        .tlr_rst_n_i(tlr_rst_n),
        .tdi_i      (tdi_i),
        .ir_ctrl_i  (ir_ctrl),
        .instr_o    (instr),
        .ir_tdo_o   (ir_tdo)
    );

    // Data registers, chain request and TDO
    tap_data_path #(
        .BUILD_ID(BUILD_ID)
    ) u_data_path (
        .tapc_tck    (tapc_tck),
        .tapc_trst_n (tapc_trst_n),
        .tlr_rst_n_i (tlr_rst_n),
        .tdi_i       (tdi_i),
        .instr_i     (instr),
        .dr_ctrl_i   (dr_ctrl),
        .ir_shift_q_i(ir_shift_q),
        .ir_tdo_i    (ir_tdo),
        .idcode_i    (fuse_idcode_i),
        .ch_tdo_i    (ch_tdo_i),
        .chain_req_o (chain_req_o),
        .tdo_o       (tdo_o),
        .tdo_en_o    (tdo_en_o)
    );

endmodule

`default_nettype wire

// ==== hw/tap_data_path.sv ====
// ----------------------------------------------------------
// TAP data path: instruction decode, internal data registers,
// DMI/SCU chain request, read mux and the TDO registers
// TDO and TDO-enable change on the falling edge of TCK
// ----------------------------------------------------------

`default_nettype none
`timescale 1ns/100ps

module tap_data_path
    import tap_pkg::*;
#(
    parameter logic [TAP_BLD_ID_WIDTH-1:0] BUILD_ID = '0
) (
    input  logic                        tapc_tck,
    input  logic                        tapc_trst_n,
    input  logic                        tlr_rst_n_i,
    input  logic                        tdi_i,
    input  tap_instr_e                  instr_i,
    input  tap_dr_ctrl_t                dr_ctrl_i,
    input  logic                        ir_shift_q_i,
    input  logic                        ir_tdo_i,
    input  logic [TAP_IDCODE_WIDTH-1:0] idcode_i,
    input  logic                        ch_tdo_i,
    output tap_chain_req_t              chain_req_o,
    output logic                        tdo_o,
    output logic                        tdo_en_o
);

    logic bypass_sel;
    logic idcode_sel;
    logic bld_id_sel;
    logic bypass_tdo;
    logic idcode_tdo;
    logic bld_id_tdo;
    logic dr_out;
    logic tdo_q;
    logic tdo_en_q;

    // ----------------------------------------------------------
    // Instruction decode
    // ----------------------------------------------------------

    always_comb begin
        bypass_sel = 1'b0;
        idcode_sel = 1'b0;
        bld_id_sel = 1'b0;
        chain_req_o.scu_sel = 1'b0;
        chain_req_o.dmi_sel = 1'b0;
        chain_req_o.ch_id   = '0;
        case (instr_i)
            IDCODE: idcode_sel = 1'b1;
            BLD_ID: bld_id_sel = 1'b1;
            // DTM control and status
            DTMCS: begin
                chain_req_o.dmi_sel = 1'b1;
                chain_req_o.ch_id   = TAP_CH_ID_WIDTH'(1);
            end
            DMI_ACCESS: begin
                chain_req_o.dmi_sel = 1'b1;
                chain_req_o.ch_id   = TAP_CH_ID_WIDTH'(2);
            end
            SCU_ACCESS: chain_req_o.scu_sel = 1'b1;
            // BYPASS and every unassigned code
            default: bypass_sel = 1'b1;
        endcase
    end

    // Chain strobes and TDI go out unchanged
    always_comb begin
        chain_req_o.capture = dr_ctrl_i.capture;
        chain_req_o.shift   = dr_ctrl_i.shift;
        chain_req_o.update  = dr_ctrl_i.update;
        chain_req_o.tdi     = tdi_i;
    end

    // ----------------------------------------------------------
    // Internal data registers
    // ----------------------------------------------------------

    // BYPASS, single bit that captures 0
    tap_dr_shift_reg #(
        .WIDTH(1)
    ) u_bypass_reg (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .tlr_rst_n_i  (tlr_rst_n_i),
        .sel_i        (bypass_sel),
        .dr_ctrl_i    (dr_ctrl_i),
        .tdi_i        (tdi_i),
        .capture_val_i(1'b0),
        .tdo_o        (bypass_tdo)
    );

    // IDCODE from the fuse input
    tap_dr_shift_reg #(
        .WIDTH(TAP_IDCODE_WIDTH)
    ) u_idcode_reg (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .tlr_rst_n_i  (tlr_rst_n_i),
        .sel_i        (idcode_sel),
        .dr_ctrl_i    (dr_ctrl_i),
        .tdi_i        (tdi_i),
        .capture_val_i(idcode_i),
        .tdo_o        (idcode_tdo)
    );

    tap_dr_shift_reg #(
        .WIDTH(TAP_BLD_ID_WIDTH)
    ) u_bld_id_reg (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .tlr_rst_n_i  (tlr_rst_n_i),
        .sel_i        (bld_id_sel),
        .dr_ctrl_i    (dr_ctrl_i),
        .tdi_i        (tdi_i),
        .capture_val_i(BUILD_ID),
        .tdo_o        (bld_id_tdo)
    );

    // ----------------------------------------------------------
    // Read mux and TDO registers
    // ----------------------------------------------------------

    always_comb begin
        if (chain_req_o.dmi_sel || chain_req_o.scu_sel) begin
            dr_out = ch_tdo_i;
        end else if (idcode_sel) begin
            dr_out = idcode_tdo;
        end else if (bld_id_sel) begin
            dr_out = bld_id_tdo;
        end else begin
            dr_out = bypass_tdo;
        end
    end

    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            tdo_q    <= 1'b0;
            tdo_en_q <= 1'b0;
        end else if (!tlr_rst_n_i) begin
            tdo_q    <= 1'b0;
            tdo_en_q <= 1'b0;
        end else begin
            tdo_en_q <= dr_ctrl_i.shift | ir_shift_q_i;
            // DR shift wins, then IR shift, else idle low
            if (dr_ctrl_i.shift) begin
                tdo_q <= dr_out;
            end else if (ir_shift_q_i) begin
                tdo_q <= ir_tdo_i;
            end else begin
                tdo_q <= 1'b0;
            end
        end
    end

    assign tdo_o    = tdo_q;
    assign tdo_en_o = tdo_en_q;

endmodule

`default_nettype wire

// ==== hw/tap_dr_shift_reg.sv ====
// ----------------------------------------------------------
// Generic capture-and-shift data register
// Serves BYPASS, IDCODE and BUILD ID, LSB is shifted out first
// ----------------------------------------------------------

`default_nettype none
`timescale 1ns/100ps

module tap_dr_shift_reg
    import tap_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic             tapc_tck,
    input  logic             tapc_trst_n,
    input  logic             tlr_rst_n_i,
    input  logic             sel_i,
    input  tap_dr_ctrl_t     dr_ctrl_i,
    input  logic             tdi_i,
    input  logic [WIDTH-1:0] capture_val_i,
    output logic             tdo_o
);

    logic [WIDTH-1:0] shift_q;
    logic [WIDTH-1:0] shift_val;

    // Right shift with TDI at the top, single bit just takes TDI
    if (WIDTH == 1) begin : g_single
        assign shift_val = tdi_i;
    end else begin : g_multi
        assign shift_val = {tdi_i, shift_q[WIDTH-1:1]};
    end

    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            shift_q <= '0;
        end else if (!tlr_rst_n_i) begin
            shift_q <= '0;
        end else if (sel_i && dr_ctrl_i.capture) begin
            shift_q <= capture_val_i;
        end else if (sel_i && dr_ctrl_i.shift) begin
            shift_q <= shift_val;
        end
    end

    assign tdo_o = shift_q[0];

endmodule

`default_nettype wire

// ==== hw/tap_fsm.sv ====
// ----------------------------------------------------------
// TAP state machine with the IR and DR control strobes
// State advances on the rising edge of TCK according to TMS
// Also produces the synchronous reset for Test-Logic-Reset
// ----------------------------------------------------------

`default_nettype none
`timescale 1ns/100ps

module tap_fsm
    import tap_pkg::*;
(
    input  logic         tapc_tck,
    input  logic         tapc_trst_n,
    input  logic         tms_i,
    output tap_ir_ctrl_t ir_ctrl_o,
    output tap_dr_ctrl_t dr_ctrl_o,
    output logic         ir_shift_q_o,
    output logic         tlr_rst_n_o
);

    tap_state_e   state_q;
    tap_state_e   state_d;
    tap_dr_ctrl_t dr_ctrl_q;
    logic         ir_shift_q;
    logic         tlr_rst_n_q;

    // ----------------------------------------------------------
    // State register and next-state table
    // ----------------------------------------------------------

    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            state_q <= RESET;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            RESET:       state_d = tms_i ? RESET       : IDLE;
            IDLE:        state_d = tms_i ? DR_SEL_SCAN : IDLE;
            // DR column
            DR_SEL_SCAN: state_d = tms_i ? IR_SEL_SCAN : DR_CAPTURE;
            DR_CAPTURE:  state_d = tms_i ? DR_EXIT1    : DR_SHIFT;
            DR_SHIFT:    state_d = tms_i ? DR_EXIT1    : DR_SHIFT;
            DR_EXIT1:    state_d = tms_i ? DR_UPDATE   : DR_PAUSE;
            DR_PAUSE:    state_d = tms_i ? DR_EXIT2    : DR_PAUSE;
            DR_EXIT2:    state_d = tms_i ? DR_UPDATE   : DR_SHIFT;
            DR_UPDATE:   state_d = tms_i ? DR_SEL_SCAN : IDLE;
            // IR column
            IR_SEL_SCAN: state_d = tms_i ? RESET       : IR_CAPTURE;
            IR_CAPTURE:  state_d = tms_i ? IR_EXIT1    : IR_SHIFT;
            IR_SHIFT:    state_d = tms_i ? IR_EXIT1    : IR_SHIFT;
            IR_EXIT1:    state_d = tms_i ? IR_UPDATE   : IR_PAUSE;
            IR_PAUSE:    state_d = tms_i ? IR_EXIT2    : IR_PAUSE;
            IR_EXIT2:    state_d = tms_i ? IR_UPDATE   : IR_SHIFT;
            IR_UPDATE:   state_d = tms_i ? DR_SEL_SCAN : IDLE;
            default:     state_d = state_q;
        endcase
    end

    // ----------------------------------------------------------
    // Synchronous reset, low while in Test-Logic-Reset
    // ----------------------------------------------------------

    // Falling edge, so it is settled before the next rising edge
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            tlr_rst_n_q <= 1'b0;
        end else begin
            tlr_rst_n_q <= (state_q != RESET);
        end
    end

    // ----------------------------------------------------------
    // Control strobes
    // ----------------------------------------------------------

    // IR strobes straight from the current state
    always_comb begin
        ir_ctrl_o.capture = (state_q == IR_CAPTURE);
        ir_ctrl_o.shift   = (state_q == IR_SHIFT);
        ir_ctrl_o.update  = (state_q == IR_UPDATE);
    end

    // Registered from the next state, so they line up with state_q
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            dr_ctrl_q  <= '0;
            ir_shift_q <= 1'b0;
        end else if (!tlr_rst_n_q) begin
            dr_ctrl_q  <= '0;
            ir_shift_q <= 1'b0;
        end else begin
            dr_ctrl_q.capture <= (state_d == DR_CAPTURE);
            dr_ctrl_q.shift   <= (state_d == DR_SHIFT);
            dr_ctrl_q.update  <= (state_d == DR_UPDATE);
            ir_shift_q        <= (state_d == IR_SHIFT);
        end
    end

    assign dr_ctrl_o    = dr_ctrl_q;
    assign ir_shift_q_o = ir_shift_q;
    assign tlr_rst_n_o  = tlr_rst_n_q;

endmodule

`default_nettype wire

// ==== hw/tap_instr_reg.sv ====
// ----------------------------------------------------------
// Instruction shift register and instruction register
// Shift register works on the rising edge of TCK, the
// instruction register loads on the falling edge in Update-IR
// ----------------------------------------------------------

`default_nettype none
`timescale 1ns/100ps

module tap_instr_reg
    import tap_pkg::*;
(
    input  logic         tapc_tck,
    input  logic         tapc_trst_n,
    input  logic         tlr_rst_n_i,
    input  logic         tdi_i,
    input  tap_ir_ctrl_t ir_ctrl_i,
    output tap_instr_e   instr_o,
    output logic         ir_tdo_o
);

    logic [TAP_IR_WIDTH-1:0] ir_shift_q;
    tap_instr_e              instr_q;

    // ----------------------------------------------------------
    // Shift register
    // ----------------------------------------------------------

    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            ir_shift_q <= '0;
        end else if (!tlr_rst_n_i) begin
            ir_shift_q <= '0;
        end else if (ir_ctrl_i.capture) begin
            // Fixed capture pattern 00001
            ir_shift_q <= TAP_IR_WIDTH'(1);
        end else if (ir_ctrl_i.shift) begin
            // TDI enters at the top, LSB leaves towards TDO
            ir_shift_q <= {tdi_i, ir_shift_q[TAP_IR_WIDTH-1:1]};
        end
    end

    // ----------------------------------------------------------
    // Instruction register
    // ----------------------------------------------------------

    // Reset value is IDCODE in both reset cases
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            instr_q <= IDCODE;
        end else if (!tlr_rst_n_i) begin
            instr_q <= IDCODE;
        end else if (ir_ctrl_i.update) begin
            instr_q <= tap_instr_e'(ir_shift_q);
        end
    end

    assign instr_o  = instr_q;
    assign ir_tdo_o = ir_shift_q[0];

endmodule

`default_nettype wire

// ==== hw/tap_pkg.sv ====
// ----------------------------------------------------------
// Shared widths, enums and control structs of the JTAG TAP
// controller for the RISC-V debug transport
// Imported by wildcard in every RTL module header
// ----------------------------------------------------------

`default_nettype none

package tap_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------

    localparam int TAP_IR_WIDTH     = 5;
    localparam int TAP_IDCODE_WIDTH = 32;
    localparam int TAP_BLD_ID_WIDTH = 32;
    // DMI/SCU chain identifier
    localparam int TAP_CH_ID_WIDTH  = 2;

    // ----------------------------------------------------------
    // TAP states, IEEE 1149.1 state diagram
    // ----------------------------------------------------------

    typedef enum logic [3:0] {
        RESET       = 4'd0,
        IDLE        = 4'd1,
        DR_SEL_SCAN = 4'd2,
        DR_CAPTURE  = 4'd3,
        DR_SHIFT    = 4'd4,
        DR_EXIT1    = 4'd5,
        DR_PAUSE    = 4'd6,
        DR_EXIT2    = 4'd7,
        DR_UPDATE   = 4'd8,
        IR_SEL_SCAN = 4'd9,
        IR_CAPTURE  = 4'd10,
        IR_SHIFT    = 4'd11,
        IR_EXIT1    = 4'd12,
        IR_PAUSE    = 4'd13,
        IR_EXIT2    = 4'd14,
        IR_UPDATE   = 4'd15
    } tap_state_e;

    // Instruction opcodes, unlisted codes select BYPASS
    typedef enum logic [TAP_IR_WIDTH-1:0] {
        IDCODE     = 5'h01,
        BLD_ID     = 5'h04,
        SCU_ACCESS = 5'h09,
        DTMCS      = 5'h10,
        DMI_ACCESS = 5'h11,
        BYPASS     = 5'h1F
    } tap_instr_e;

    // ----------------------------------------------------------
    // Control structs
    // ----------------------------------------------------------

    // IR strobes, decoded from the current state
    typedef struct packed {
        logic capture;
        logic shift;
        logic update;
    } tap_ir_ctrl_t;

    // DR strobes, registered from the next state
    typedef struct packed {
        logic capture;
        logic shift;
        logic update;
    } tap_dr_ctrl_t;

    // Request towards the external DMI/SCU scan chains
    typedef struct packed {
        logic                       scu_sel;
        logic                       dmi_sel;
        logic [TAP_CH_ID_WIDTH-1:0] ch_id;
        logic                       capture;
        logic                       shift;
        logic                       update;
        logic                       tdi;
    } tap_chain_req_t;

endpackage

`default_nettype wire

// ==== verification/tb_tap_ctrl.sv ====
// ----------------------------------------------------------
// Directed testbench for the JTAG TAP controller
// Plays the probe on TMS/TDI and checks TDO, the instruction
// register and the DMI/SCU chain request against JTAG rules
// ----------------------------------------------------------

`default_nettype none
`timescale 1ns/100ps

module tb_tap_ctrl
    import tap_pkg::*;
();

    localparam logic [31:0] BUILD_ID   = 32'h2021_0607;
    localparam int          WAIT_LIMIT = 20;

    logic           tapc_tck;
    logic           tapc_trst_n;
    logic           tms;
    logic           tdi;
    logic           tdo;
    logic           tdo_en;
    logic [31:0]    fuse_idcode;
    tap_chain_req_t chain_req;
    logic           ch_tdo;

    // Expected IDCODE that is also driven on the fuse input
    logic [31:0]    fuse_word;
    logic [15:0]    lfsr_q;
    string          cur_test;
    int             test_errs;
    int             total_errs;
    int             tests_run;
    int             tests_failed;

    // Per-scan monitor of tdo_en and the chain strobes
    int             en_cnt;
    int             cap_cnt;
    int             shift_cnt;
    int             upd_cnt;
    tap_chain_req_t cap_snap;
    tap_chain_req_t shift_snap;
    tap_chain_req_t upd_snap;
    // Chain TDI seen in each Shift-DR cycle
    logic [31:0]    shift_tdi;

    // 8 ns TCK
    initial tapc_tck = 1'b0;
    always #4 tapc_tck = ~tapc_tck;

    tap_ctrl_top #(
        .BUILD_ID(BUILD_ID)
    ) u_dut (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .tms_i        (tms),
        .tdi_i        (tdi),
        .tdo_o        (tdo),
        .tdo_en_o     (tdo_en),
        .fuse_idcode_i(fuse_idcode),
        .chain_req_o  (chain_req),
        .ch_tdo_i     (ch_tdo)
    );

    // ----------------------------------------------------------
    // Random source
    // ----------------------------------------------------------

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken and filled from the LSB up
    task automatic take_random(input int nbits, output logic [31:0] word);
        int i;
        word = '0;
        for (i = 0; i < nbits; i++) begin
            lfsr_q  = lfsr_step(lfsr_q);
            word[i] = lfsr_q[0];
        end
    endtask

    // ----------------------------------------------------------
    // Reporting and compare tasks
    // ----------------------------------------------------------

    task automatic abort_run(input string why);
        $display("error in %s: %s", cur_test, why);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs != 0) begin
            tests_failed++;
            $display("test %-14s failed with %0d errors", cur_test, test_errs);
        end else begin
            $display("test %-14s ok", cur_test);
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_instr_code(input tap_instr_e exp, input tap_instr_e act);
        if (act !== exp) begin
            $display("mismatch in %s, instruction: expected %h, actual %h",
                     cur_test, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_chain(input string what, input tap_chain_req_t exp,
                               input tap_chain_req_t act);
        if (act !== exp) begin
            $display("mismatch in %s, %s: expected %b, actual %b", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    // ----------------------------------------------------------
    // JTAG driver
    // ----------------------------------------------------------

    // Wait for the next rising edge and sample before any drive
    task automatic tick();
        @(posedge tapc_tck);
        if (tdo_en) en_cnt++;
        if (chain_req.capture) begin
            cap_cnt++;
            cap_snap = chain_req;
        end
        if (chain_req.shift) begin
            if (shift_cnt == 0) shift_snap = chain_req;
            if (shift_cnt < 32) shift_tdi[shift_cnt] = chain_req.tdi;
            shift_cnt++;
        end
        if (chain_req.update) begin
            upd_cnt++;
            upd_snap = chain_req;
        end
    endtask

    // Pins change on this edge and the DUT sees them on the next one
    task automatic step(input logic tms_v, input logic tdi_v, input logic ch_v);
        tms    <= tms_v;
        tdi    <= tdi_v;
        ch_tdo <= ch_v;
        tick();
    endtask

    task automatic goto_reset();
        repeat (5) step(1'b1, 1'b0, 1'b0);
        step(1'b0, 1'b0, 1'b0);
        step(1'b0, 1'b0, 1'b0);
    endtask

    // Scan from Idle back to Idle for n >= 2 bits
    // TDO bit i lands in dout[i]
    task automatic scan_reg(input logic is_ir, input int n, input logic [31:0] din,
                            input logic [31:0] chin, output logic [31:0] dout);
        int waited;
        int i;
        dout       = '0;
        waited     = 0;
        en_cnt     = 0;
        cap_cnt    = 0;
        shift_cnt  = 0;
        upd_cnt    = 0;
        cap_snap   = '0;
        shift_snap = '0;
        upd_snap   = '0;
        shift_tdi  = '0;
        step(1'b1, 1'b0, 1'b0);
        if (is_ir) step(1'b1, 1'b0, 1'b0);
        step(1'b0, 1'b0, 1'b0);
        // First bit waits on the pins until the shift starts
        step(1'b0, din[0], chin[0]);
        while (!tdo_en && waited < WAIT_LIMIT) begin
            waited++;
            tick();
        end
        if (!tdo_en) begin
            abort_run("tdo_en never rose after entering the shift state");
        end else begin
            dout[0] = tdo;
            for (i = 1; i < n; i++) begin
                // TMS high on the last bit moves to Exit1
                step(i == n - 1, din[i], chin[i]);
                dout[i] = tdo;
            end
            // Exit1 to Update and then back to Idle
            step(1'b1, 1'b0, 1'b0);
            step(1'b0, 1'b0, 1'b0);
        end
    endtask

    task automatic scan_ir(input logic [4:0] code, output logic [4:0] captured);
        logic [31:0] dout;
        scan_reg(1'b1, TAP_IR_WIDTH, 32'(code), '0, dout);
        captured = dout[4:0];
    endtask

    task automatic scan_dr(input int n, input logic [31:0] din, input logic [31:0] chin,
                           output logic [31:0] dout);
        scan_reg(1'b0, n, din, chin, dout);
    endtask

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------

    task automatic test_reset_values();
        start_test("reset_values");
        check_word("tdo_en", 32'h0, 32'(tdo_en));
        check_word("tdo", 32'h0, 32'(tdo));
        check_chain("request", '0, chain_req);
        check_instr_code(IDCODE, u_dut.instr);
        end_test();
    endtask

    task automatic test_idcode_scan();
        logic [31:0] dout;
        start_test("idcode_scan");
        scan_dr(32, '0, '0, dout);
        check_word("idcode", fuse_word, dout);
        check_word("tdo_en cycles", 32'd32, 32'(en_cnt));
        check_word("tdo_en after scan", 32'h0, 32'(tdo_en));
        end_test();
    endtask

    task automatic test_ir_capture();
        logic [4:0] cap;
        start_test("ir_capture");
        scan_ir(5'h07, cap);
        check_word("ir capture", 32'h1, 32'(cap));
        check_word("tdo_en cycles", 32'd5, 32'(en_cnt));
        check_instr_code(tap_instr_e'(5'h07), u_dut.instr);
        end_test();
    endtask

    task automatic test_bypass();
        logic [31:0] din;
        logic [31:0] dout;
        logic [4:0]  cap;
        start_test("bypass");
        // Opcode 0x07 still loaded from the previous test
        take_random(16, din);
        scan_dr(16, din, '0, dout);
        check_word("unassigned opcode", 32'({din[14:0], 1'b0}), dout);
        scan_ir(BYPASS, cap);
        check_instr_code(BYPASS, u_dut.instr);
        take_random(16, din);
        scan_dr(16, din, '0, dout);
        check_word("bypass", 32'({din[14:0], 1'b0}), dout);
        end_test();
    endtask

    task automatic test_bld_id();
        logic [31:0] dout;
        logic [4:0]  cap;
        start_test("bld_id");
        scan_ir(BLD_ID, cap);
        check_instr_code(BLD_ID, u_dut.instr);
        scan_dr(32, '0, '0, dout);
        check_word("build id", BUILD_ID, dout);
        end_test();
    endtask

    task automatic run_chain(input tap_instr_e code, input logic dmi, input logic scu,
                             input logic [1:0] id);
        tap_chain_req_t base;
        tap_chain_req_t exp;
        logic [31:0]    din;
        logic [31:0]    chin;
        logic [31:0]    dout;
        logic [4:0]     cap;
        base         = '0;
        base.dmi_sel = dmi;
        base.scu_sel = scu;
        base.ch_id   = id;
        scan_ir(code, cap);
        check_instr_code(code, u_dut.instr);
        check_chain("select in idle", base, chain_req);
        take_random(16, din);
        take_random(16, chin);
        scan_dr(16, din, chin, dout);
        check_word("chain tdo", chin, dout);
        check_word("chain tdi", din, shift_tdi);
        check_word("capture cycles", 32'd1, 32'(cap_cnt));
        check_word("shift cycles", 32'd16, 32'(shift_cnt));
        check_word("update cycles", 32'd1, 32'(upd_cnt));
        // TDI for the first bit is already on the pin in Capture-DR
        exp         = base;
        exp.capture = 1'b1;
        exp.tdi     = din[0];
        check_chain("capture-dr", exp, cap_snap);
        exp         = base;
        exp.shift   = 1'b1;
        exp.tdi     = din[0];
        check_chain("shift-dr", exp, shift_snap);
        exp         = base;
        exp.update  = 1'b1;
        check_chain("update-dr", exp, upd_snap);
    endtask

    task automatic test_chains();
        start_test("chains");
        run_chain(DTMCS, 1'b1, 1'b0, 2'd1);
        run_chain(DMI_ACCESS, 1'b1, 1'b0, 2'd2);
        run_chain(SCU_ACCESS, 1'b0, 1'b1, 2'd0);
        end_test();
    endtask

    task automatic test_tlr_reset();
        logic [31:0] dout;
        logic [4:0]  cap;
        start_test("tlr_reset");
        scan_ir(DMI_ACCESS, cap);
        check_instr_code(DMI_ACCESS, u_dut.instr);
        // Into Shift-DR and stay a few cycles
        step(1'b1, 1'b0, 1'b0);
        step(1'b0, 1'b0, 1'b0);
        repeat (3) step(1'b0, 1'b1, 1'b0);
        goto_reset();
        check_instr_code(IDCODE, u_dut.instr);
        check_word("tdo_en", 32'h0, 32'(tdo_en));
        check_chain("request", '0, chain_req);
        scan_dr(32, '0, '0, dout);
        check_word("idcode", fuse_word, dout);
        end_test();
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------

    initial begin
        lfsr_q       = 16'd20082;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "setup";
        take_random(32, fuse_word);
        tapc_trst_n <= 1'b0;
        tms         <= 1'b1;
        tdi         <= 1'b0;
        ch_tdo      <= 1'b0;
        fuse_idcode <= fuse_word;
        repeat (2) @(posedge tapc_tck);
        tapc_trst_n <= 1'b1;
        // Test-Logic-Reset to Idle
        step(1'b0, 1'b0, 1'b0);
        step(1'b0, 1'b0, 1'b0);

        test_reset_values();
        test_idcode_scan();
        test_ir_capture();
        test_bypass();
        test_bld_id();
        test_chains();
        test_tlr_reset();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
